//--- Makefile
# Verilator build and run for the credit issue unit

TOP := tb_credit_issue

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fails unless the pass message appears"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f build.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir

//--- build.f
rtl/credit_pkg.sv
rtl/cmd_if.sv
rtl/cmd_slice.sv
rtl/credit_gate.sv
rtl/cmd_dispatch.sv
rtl/cmd_merge.sv
rtl/credit_issue_top.sv
verif/tb_clock.sv
verif/tb_credit_issue.sv

//--- rtl/cmd_dispatch.sv
// command and charge dispatcher
//   channel decode for commands and charges
//   ready of the addressed channel back to the source

`timescale 1ns/10ps
`default_nettype none

module cmd_dispatch
    import credit_pkg::*;
#(
    parameter  int NUM_CHAN   = 4,
    parameter  int SIZE_WIDTH = 8,
    localparam int CHAN_WIDTH = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1
) (
    input  wire  [CHAN_WIDTH-1:0] s_cmd_chan,
    input  cmd_op_e               s_cmd_op,
    input  wire  [SIZE_WIDTH-1:0] s_cmd_size,
    input  wire                   s_cmd_valid,
    output logic                  s_cmd_ready,
    input  wire  [CHAN_WIDTH-1:0] charge_chan,
    input  wire  [SIZE_WIDTH-1:0] charge_size,
    input  wire                   charge_valid,
    cmd_if.source                 ch [NUM_CHAN],
    output logic [NUM_CHAN-1:0]   ch_charge_valid,
    output logic [SIZE_WIDTH-1:0] ch_charge_size
);

    logic [NUM_CHAN-1:0] chan_ready;

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        // payload fans out, valid only to the addressed channel
        assign ch[i].op    = s_cmd_op;
        assign ch[i].size  = s_cmd_size;
        assign ch[i].valid = s_cmd_valid && (s_cmd_chan == CHAN_WIDTH'(i));
        assign chan_ready[i] = ch[i].ready;

        assign ch_charge_valid[i] = charge_valid && (charge_chan == CHAN_WIDTH'(i));
    end

    assign s_cmd_ready    = chan_ready[s_cmd_chan];
    assign ch_charge_size = charge_size;

endmodule

`default_nettype wire

//--- rtl/cmd_if.sv
// command stream interface
//   op, size and valid from the source, ready from the sink
//   source and sink modports

`timescale 1ns/10ps
`default_nettype none

interface cmd_if
    import credit_pkg::*;
#(
    parameter int SIZE_WIDTH = 8
) ();

    cmd_op_e               op;
    logic [SIZE_WIDTH-1:0] size;
    logic                  valid;
    logic                  ready;

    modport source (
        output op,
        output size,
        output valid,
        input  ready
    );

    modport sink (
        input  op,
        input  size,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

//--- rtl/cmd_merge.sv
// round-robin merge of the channel streams
//   registered output held under back-pressure
//   capacity readback mux

`timescale 1ns/10ps
`default_nettype none

module cmd_merge
    import credit_pkg::*;
#(
    parameter  int NUM_CHAN       = 4,
    parameter  int SIZE_WIDTH     = 8,
    parameter  int CAPACITY_WIDTH = 16,
    localparam int CHAN_WIDTH     = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1
) (
    input  wire                       clk,
    input  wire                       reset,
    cmd_if.sink                       ch [NUM_CHAN],
    input  wire  [CAPACITY_WIDTH-1:0] capacity [NUM_CHAN],
    output logic [CHAN_WIDTH-1:0]     m_cmd_chan,
    output cmd_op_e                   m_cmd_op,
    output logic [SIZE_WIDTH-1:0]     m_cmd_size,
    output logic                      m_cmd_valid,
    input  wire                       m_cmd_ready,
    input  wire  [CHAN_WIDTH-1:0]     cap_chan,
    output logic [CAPACITY_WIDTH-1:0] cap_value
);

    logic [NUM_CHAN-1:0]   ch_valid;
    logic [NUM_CHAN-1:0]   ch_ready;
    cmd_op_e               ch_op   [NUM_CHAN];
    logic [SIZE_WIDTH-1:0] ch_size [NUM_CHAN];

    logic [CHAN_WIDTH-1:0] ptr;
    logic [CHAN_WIDTH-1:0] grant_idx;
    logic                  grant_valid;
    logic                  load;

    function automatic logic [CHAN_WIDTH-1:0] rr_index(
        input logic [CHAN_WIDTH-1:0] base,
        input int                    offset
    );
        return CHAN_WIDTH'((int'(base) + offset) % NUM_CHAN);
    endfunction

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        assign ch_valid[i] = ch[i].valid;
        assign ch_op[i]    = ch[i].op;
        assign ch_size[i]  = ch[i].size;
        assign ch[i].ready = ch_ready[i];
        assign ch_ready[i] = load && grant_valid && (grant_idx == CHAN_WIDTH'(i));
    end

    // ----------------------------------------
    // arbiter
    // ----------------------------------------
    // first valid channel at or after ptr
    always_comb begin
        grant_valid = 1'b0;
        grant_idx   = ptr;
        for (int k = 0; k < NUM_CHAN; k++) begin
            if (!grant_valid && ch_valid[rr_index(ptr, k)]) begin
                grant_valid = 1'b1;
                grant_idx   = rr_index(ptr, k);
            end
        end
    end

    assign load = !m_cmd_valid || m_cmd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            m_cmd_valid <= 1'b0;
            ptr         <= '0;
        end else if (load) begin
            m_cmd_valid <= grant_valid;
            if (grant_valid) begin
                ptr <= rr_index(grant_idx, 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && grant_valid) begin
            m_cmd_chan <= grant_idx;
            m_cmd_op   <= ch_op[grant_idx];
            m_cmd_size <= ch_size[grant_idx];
        end
    end

    // capacity readback
    assign cap_value = capacity[cap_chan];

endmodule

`default_nettype wire

//--- rtl/cmd_slice.sv
// register slice for one command stream
//   output register plus one skid entry
//   ready toward the source comes from a flop

`timescale 1ns/10ps
`default_nettype none

module cmd_slice
    import credit_pkg::*;
#(
    parameter int SIZE_WIDTH = 8
) (
    input wire      clk,
    input wire      reset,
    cmd_if.sink     s,
    cmd_if.source   m
);

    logic                  in_ready;
    logic                  out_valid;
    cmd_op_e               out_op;
    logic [SIZE_WIDTH-1:0] out_size;
    logic                  skid_valid;
    cmd_op_e               skid_op;
    logic [SIZE_WIDTH-1:0] skid_size;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_ready   <= 1'b0;
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!out_valid || m.ready) begin
            // output register free, drain skid first
            if (skid_valid) begin
                out_valid  <= 1'b1;
                out_op     <= skid_op;
                out_size   <= skid_size;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= s.valid && in_ready;
                if (s.valid && in_ready) begin
                    out_op   <= s.op;
                    out_size <= s.size;
                end
            end
            in_ready <= 1'b1;
        end else if (s.valid && in_ready) begin
            // output stalled, park the beat
            skid_valid <= 1'b1;
            skid_op    <= s.op;
            skid_size  <= s.size;
            in_ready   <= 1'b0;
        end
    end

    assign s.ready = in_ready;
    assign m.valid = out_valid;
    assign m.op    = out_op;
    assign m.size  = out_size;

endmodule

`default_nettype wire

//--- rtl/credit_gate.sv
// credit gate for one channel
//   input slice, head register with cost
//   capacity counter with precomputed add and add-minus-cost
//   issue check, output slice

`timescale 1ns/10ps
`default_nettype none

module credit_gate
    import credit_pkg::*;
#(
    parameter int CAPACITY_WIDTH   = 16,
    parameter int SIZE_WIDTH       = 8,
    parameter int INITIAL_CAPACITY = 64
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       charge_valid,
    input  wire  [SIZE_WIDTH-1:0]     charge_size,
    cmd_if.sink                       s,
    cmd_if.source                     m,
    output logic [CAPACITY_WIDTH-1:0] capacity
);

    cmd_if #(.SIZE_WIDTH(SIZE_WIDTH)) in_q ();
    cmd_if #(.SIZE_WIDTH(SIZE_WIDTH)) out_d ();

    cmd_slice #(.SIZE_WIDTH(SIZE_WIDTH)) i_slice_in (
        .clk   (clk),
        .reset (reset),
        .s     (s),
        .m     (in_q)
    );

    // ----------------------------------------
    // head register
    // ----------------------------------------
    cmd_op_e                 rx_op;
    logic [SIZE_WIDTH-1:0]   rx_size;
    logic [CAPACITY_WIDTH-1:0] rx_cost;
    logic                    rx_valid;
    logic                    rx_ready;

    assign in_q.ready = !rx_valid || rx_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_valid <= 1'b0;
            rx_cost  <= '0;
        end else if (in_q.ready) begin
            rx_valid <= in_q.valid;
            // empty head costs nothing
            rx_cost  <= in_q.valid
                ? CAPACITY_WIDTH'(in_q.size) + CAPACITY_WIDTH'(COST_OFFSET)
                : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_q.ready) begin
            rx_op   <= in_q.op;
            rx_size <= in_q.size;
        end
    end

    // ----------------------------------------
    // capacity counter
    // ----------------------------------------
    logic [CAPACITY_WIDTH-1:0] charge_q;
    logic [CAPACITY_WIDTH-1:0] cap_add;
    logic [CAPACITY_WIDTH-1:0] cap_add_sub;
    logic                      select_sub;
    logic                      issue_enable;

    assign issue_enable = (capacity >= rx_cost);

    always_ff @(posedge clk) begin
        if (reset) begin
            charge_q   <= '0;
            cap_add    <= CAPACITY_WIDTH'(INITIAL_CAPACITY);
            select_sub <= 1'b0;
        end else begin
            charge_q   <= charge_valid ? CAPACITY_WIDTH'(charge_size) : '0;
            cap_add    <= capacity + charge_q;
            select_sub <= issue_enable && rx_ready;
        end
    end

    // only picked when select_sub is set
    always_ff @(posedge clk) begin
        cap_add_sub <= capacity + charge_q - rx_cost;
    end

    assign capacity = select_sub ? cap_add_sub : cap_add;

    // ----------------------------------------
    // issue
    // ----------------------------------------
    assign rx_ready    = out_d.ready && issue_enable;
    assign out_d.op    = rx_op;
    assign out_d.size  = rx_size;
    assign out_d.valid = rx_valid && issue_enable;

    cmd_slice #(.SIZE_WIDTH(SIZE_WIDTH)) i_slice_out (
        .clk   (clk),
        .reset (reset),
        .s     (out_d),
        .m     (m)
    );

endmodule

`default_nettype wire

//--- rtl/credit_issue_top.sv
// credit-gated command issue unit, top level
//   dispatcher, one credit gate per channel, round-robin merger
//   plain stream ports on both sides

`timescale 1ns/10ps
`default_nettype none

module credit_issue_top
    import credit_pkg::*;
#(
    parameter  int NUM_CHAN         = 4,
    parameter  int CAPACITY_WIDTH   = 16,
    parameter  int SIZE_WIDTH       = 8,
    parameter  int INITIAL_CAPACITY = 64,
    localparam int CHAN_WIDTH       = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire  [CHAN_WIDTH-1:0]     s_cmd_chan,
    input  cmd_op_e                   s_cmd_op,
    input  wire  [SIZE_WIDTH-1:0]     s_cmd_size,
    input  wire                       s_cmd_valid,
    output logic                      s_cmd_ready,
    input  wire  [CHAN_WIDTH-1:0]     charge_chan,
    input  wire  [SIZE_WIDTH-1:0]     charge_size,
    input  wire                       charge_valid,
    output logic [CHAN_WIDTH-1:0]     m_cmd_chan,
    output cmd_op_e                   m_cmd_op,
    output logic [SIZE_WIDTH-1:0]     m_cmd_size,
    output logic                      m_cmd_valid,
    input  wire                       m_cmd_ready,
    input  wire  [CHAN_WIDTH-1:0]     cap_chan,
    output logic [CAPACITY_WIDTH-1:0] cap_value
);

    cmd_if #(.SIZE_WIDTH(SIZE_WIDTH)) gate_in  [NUM_CHAN] ();
    cmd_if #(.SIZE_WIDTH(SIZE_WIDTH)) gate_out [NUM_CHAN] ();

    logic [NUM_CHAN-1:0]       ch_charge_valid;
    logic [SIZE_WIDTH-1:0]     ch_charge_size;
    logic [CAPACITY_WIDTH-1:0] capacity [NUM_CHAN];

    cmd_dispatch #(
        .NUM_CHAN   (NUM_CHAN),
        .SIZE_WIDTH (SIZE_WIDTH)
    ) i_cmd_dispatch (
        .s_cmd_chan      (s_cmd_chan),
        .s_cmd_op        (s_cmd_op),
        .s_cmd_size      (s_cmd_size),
        .s_cmd_valid     (s_cmd_valid),
        .s_cmd_ready     (s_cmd_ready),
        .charge_chan     (charge_chan),
        .charge_size     (charge_size),
        .charge_valid    (charge_valid),
        .ch              (gate_in),
        .ch_charge_valid (ch_charge_valid),
        .ch_charge_size  (ch_charge_size)
    );

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_gate
        credit_gate #(
            .CAPACITY_WIDTH   (CAPACITY_WIDTH),
            .SIZE_WIDTH       (SIZE_WIDTH),
            .INITIAL_CAPACITY (INITIAL_CAPACITY)
        ) i_credit_gate (
            .clk          (clk),
            .reset        (reset),
            .charge_valid (ch_charge_valid[i]),
            .charge_size  (ch_charge_size),
            .s            (gate_in[i]),
            .m            (gate_out[i]),
            .capacity     (capacity[i])
        );
    end

    cmd_merge #(
        .NUM_CHAN       (NUM_CHAN),
        .SIZE_WIDTH     (SIZE_WIDTH),
        .CAPACITY_WIDTH (CAPACITY_WIDTH)
    ) i_cmd_merge (
        .clk         (clk),
        .reset       (reset),
        .ch          (gate_out),
        .capacity    (capacity),
        .m_cmd_chan  (m_cmd_chan),
        .m_cmd_op    (m_cmd_op),
        .m_cmd_size  (m_cmd_size),
        .m_cmd_valid (m_cmd_valid),
        .m_cmd_ready (m_cmd_ready),
        .cap_chan    (cap_chan),
        .cap_value   (cap_value)
    );

endmodule

`default_nettype wire

//--- rtl/credit_pkg.sv
// shared definitions for the credit issue unit
//   cmd_op_e     command opcode
//   COST_OFFSET  added to a command size to give its cost

`default_nettype none

package credit_pkg;

    // ----------------------------------------
    // opcodes
    // ----------------------------------------
    typedef enum logic [1:0] {
        op_read  = 2'd0,
        op_write = 2'd1,
        op_flush = 2'd2,
        op_nop   = 2'd3
    } cmd_op_e;

    // ----------------------------------------
    // cost rule
    // ----------------------------------------
    // a size of n moves n+1 units
    localparam int COST_OFFSET = 1;

endpackage

`default_nettype wire

//--- verif/tb_clock.sv
// testbench clock generator
//   free-running clock, period in ns

`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_credit_issue.sv
// testbench top for the credit issue unit
//   clock, reset, command and charge drivers
//   per-channel expected queues and credit ledger
//   output monitor with order, hold and credit checks
//   watchdog

`timescale 1ns/10ps
`default_nettype none

module tb_credit_issue
    import credit_pkg::*;
();

    localparam int NUM_CHAN         = 4;
    localparam int CAPACITY_WIDTH   = 16;
    localparam int SIZE_WIDTH       = 8;
    localparam int INITIAL_CAPACITY = 64;
    localparam int CHAN_WIDTH       = $clog2(NUM_CHAN);
    localparam int CLK_PERIOD_NS    = 4;
    localparam logic [31:0] SEED    = 32'hc83ea90d;

    // four full-size commands use up a channel exactly
    localparam int FULL_SIZE      = INITIAL_CAPACITY / 4 - COST_OFFSET;
    localparam int TAIL_SIZE      = 7;
    localparam int NUM_RANDOM     = 200;
    localparam int TOTAL_CMDS     = 8 + NUM_RANDOM;
    localparam int MAX_CMDS       = 256;
    localparam int SETTLE_CYCLES  = 40;
    localparam int CYCLES_PER_CMD = 50;
    localparam int TIMEOUT_NS     =
        (TOTAL_CMDS * CYCLES_PER_CMD + 8 * SETTLE_CYCLES) * CLK_PERIOD_NS;

    logic                      clk;
    logic                      reset;
    logic [CHAN_WIDTH-1:0]     s_cmd_chan;
    cmd_op_e                   s_cmd_op;
    logic [SIZE_WIDTH-1:0]     s_cmd_size;
    logic                      s_cmd_valid;
    logic                      s_cmd_ready;
    logic [CHAN_WIDTH-1:0]     charge_chan;
    logic [SIZE_WIDTH-1:0]     charge_size;
    logic                      charge_valid;
    logic [CHAN_WIDTH-1:0]     m_cmd_chan;
    cmd_op_e                   m_cmd_op;
    logic [SIZE_WIDTH-1:0]     m_cmd_size;
    logic                      m_cmd_valid;
    logic                      m_cmd_ready;
    logic [CHAN_WIDTH-1:0]     cap_chan;
    logic [CAPACITY_WIDTH-1:0] cap_value;

    // reference model
    cmd_op_e exp_op    [NUM_CHAN][MAX_CMDS];
    int      exp_size  [NUM_CHAN][MAX_CMDS];
    int      wr_ptr    [NUM_CHAN];
    int      rd_ptr    [NUM_CHAN];
    int      charged   [NUM_CHAN];
    int      committed [NUM_CHAN];
    int      spent     [NUM_CHAN];
    int      err_value;
    int      err_credit;
    int      err_other;

    logic [31:0]           rng;
    logic [31:0]           bp_rng;
    logic                  bp_enable;
    logic                  hold_pending;
    logic [CHAN_WIDTH-1:0] held_chan;
    cmd_op_e               held_op;
    logic [SIZE_WIDTH-1:0] held_size;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) i_tb_clock (.clk(clk));

    credit_issue_top #(
        .NUM_CHAN         (NUM_CHAN),
        .CAPACITY_WIDTH   (CAPACITY_WIDTH),
        .SIZE_WIDTH       (SIZE_WIDTH),
        .INITIAL_CAPACITY (INITIAL_CAPACITY)
    ) i_credit_issue_top (
        .clk          (clk),
        .reset        (reset),
        .s_cmd_chan   (s_cmd_chan),
        .s_cmd_op     (s_cmd_op),
        .s_cmd_size   (s_cmd_size),
        .s_cmd_valid  (s_cmd_valid),
        .s_cmd_ready  (s_cmd_ready),
        .charge_chan  (charge_chan),
        .charge_size  (charge_size),
        .charge_valid (charge_valid),
        .m_cmd_chan   (m_cmd_chan),
        .m_cmd_op     (m_cmd_op),
        .m_cmd_size   (m_cmd_size),
        .m_cmd_valid  (m_cmd_valid),
        .m_cmd_ready  (m_cmd_ready),
        .cap_chan     (cap_chan),
        .cap_value    (cap_value)
    );

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int pending_total();
        int sum;
        sum = 0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            sum += wr_ptr[c] - rd_ptr[c];
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            err_value++;
            $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic expect_pending(input int chan, input int count);
        assert (wr_ptr[chan] - rd_ptr[chan] == count) else begin
            err_other++;
            $display("channel %0d has %0d commands waiting where %0d were expected",
                     chan, wr_ptr[chan] - rd_ptr[chan], count);
        end
    endtask

    task automatic send_cmd(input int chan, input cmd_op_e op, input int size);
        @(posedge clk);
        s_cmd_chan  <= CHAN_WIDTH'(chan);
        s_cmd_op    <= op;
        s_cmd_size  <= SIZE_WIDTH'(size);
        s_cmd_valid <= 1'b1;
        exp_op[chan][wr_ptr[chan]]   = op;
        exp_size[chan][wr_ptr[chan]] = size;
        wr_ptr[chan]++;
        committed[chan] += size + COST_OFFSET;
        @(negedge clk);
        while (!s_cmd_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        s_cmd_valid <= 1'b0;
    endtask

    task automatic pulse_charge(input int chan, input int size);
        @(posedge clk);
        charge_chan  <= CHAN_WIDTH'(chan);
        charge_size  <= SIZE_WIDTH'(size);
        charge_valid <= 1'b1;
        charged[chan] += size;
        @(posedge clk);
        charge_valid <= 1'b0;
    endtask

    task automatic check_capacity(input int chan);
        @(posedge clk);
        cap_chan <= CHAN_WIDTH'(chan);
        @(negedge clk);
        check_value($sformatf("cap_value[%0d]", chan),
                    INITIAL_CAPACITY + charged[chan] - spent[chan], int'(cap_value));
    endtask

    task automatic settle();
        repeat (SETTLE_CYCLES) @(posedge clk);
    endtask

    // ----------------------------------------
    // monitors
    // ----------------------------------------
    always @(negedge clk) begin : out_monitor
        int c;
        int rd;
        if (!reset && m_cmd_valid && m_cmd_ready) begin
            c  = int'(m_cmd_chan);
            rd = rd_ptr[c];
            assert (rd < wr_ptr[c]) else begin
                err_other++;
                $display("command out on channel %0d at %0t with none expected", c, $time);
            end
            if (rd < wr_ptr[c]) begin
                check_value("m_cmd_op", int'(exp_op[c][rd]), int'(m_cmd_op));
                check_value("m_cmd_size", exp_size[c][rd], int'(m_cmd_size));
                spent[c] += exp_size[c][rd] + COST_OFFSET;
                rd_ptr[c] = rd + 1;
            end
            assert (spent[c] <= INITIAL_CAPACITY + charged[c]) else begin
                err_credit++;
                $display("channel %0d issued %0d units against a budget of %0d at %0t",
                         c, spent[c], INITIAL_CAPACITY + charged[c], $time);
            end
        end
    end

    // output must not move while stalled
    always @(negedge clk) begin : hold_monitor
        if (!reset && hold_pending) begin
            check_value("m_cmd_valid", 1, int'(m_cmd_valid));
            check_value("m_cmd_chan", int'(held_chan), int'(m_cmd_chan));
            check_value("m_cmd_op", int'(held_op), int'(m_cmd_op));
            check_value("m_cmd_size", int'(held_size), int'(m_cmd_size));
        end
        hold_pending = !reset && m_cmd_valid && !m_cmd_ready;
        held_chan    = m_cmd_chan;
        held_op      = m_cmd_op;
        held_size    = m_cmd_size;
    end

    always @(posedge clk) begin : back_pressure
        if (bp_enable) begin
            bp_rng = lcg_next(bp_rng);
            m_cmd_ready <= (bp_rng[31:30] != 2'd0);
        end else begin
            m_cmd_ready <= 1'b1;
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns with the test still running", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : main
        int      chan;
        int      size;
        cmd_op_e op;
        rng        = SEED;
        bp_rng     = lcg_next(SEED);
        err_value  = 0;
        err_credit = 0;
        err_other  = 0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            wr_ptr[c]    = 0;
            rd_ptr[c]    = 0;
            charged[c]   = 0;
            committed[c] = 0;
            spent[c]     = 0;
        end
        reset        <= 1'b1;
        s_cmd_chan   <= '0;
        s_cmd_op     <= op_nop;
        s_cmd_size   <= '0;
        s_cmd_valid  <= 1'b0;
        charge_chan  <= '0;
        charge_size  <= '0;
        charge_valid <= 1'b0;
        m_cmd_ready  <= 1'b1;
        cap_chan     <= '0;
        bp_enable    <= 1'b0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("s_cmd_ready", 0, int'(s_cmd_ready));
        check_value("m_cmd_valid", 0, int'(m_cmd_valid));
        @(posedge clk);
        reset <= 1'b0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            check_capacity(c);
        end

        // channel 0 runs dry and the fifth command waits
        for (int k = 0; k < 4; k++) begin
            send_cmd(0, op_write, FULL_SIZE);
        end
        send_cmd(0, op_read, TAIL_SIZE);
        settle();
        expect_pending(0, 1);
        check_capacity(0);

        // channel 1 still flows past the stall
        for (int k = 0; k < 3; k++) begin
            send_cmd(1, op_flush, 3);
        end
        settle();
        expect_pending(1, 0);
        expect_pending(0, 1);

        pulse_charge(0, TAIL_SIZE + COST_OFFSET);
        settle();
        expect_pending(0, 0);
        check_capacity(0);
        check_capacity(1);

        // random traffic with charges that keep every channel solvent
        @(posedge clk);
        bp_enable <= 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rng  = lcg_next(rng);
            chan = int'(rng[31:30]) % NUM_CHAN;
            size = int'(rng[27:24]);
            op   = cmd_op_e'(rng[21:20]);
            if (committed[chan] + size + COST_OFFSET > INITIAL_CAPACITY + charged[chan]) begin
                pulse_charge(chan, size + COST_OFFSET);
            end else if (rng[15:14] == 2'd0) begin
                pulse_charge(chan, int'(rng[11:8]));
            end
            send_cmd(chan, op, size);
        end
        while (pending_total() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        bp_enable <= 1'b0;
        settle();
        for (int c = 0; c < NUM_CHAN; c++) begin
            expect_pending(c, 0);
            check_capacity(c);
        end

        $display("errors: value %0d, credit %0d, other %0d", err_value, err_credit, err_other);
        if (err_value + err_credit + err_other == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
